// ==== files.f ====
logic/tpu_types_pkg.sv
logic/tpu_regs_pkg.sv
logic/tpu_cfg_regs.sv
logic/tpu_control.sv
logic/mat_mul_unit.sv
logic/vector_post_unit.sv
logic/tpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_tpu.sv

// ==== logic/mat_mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mat_mul_unit #(
    parameter int VEC_LEN = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mat_wr,
    input  logic                         mat_is_vector,
    input  logic [2*$clog2(VEC_LEN)-1:0] mat_idx,
    input  tpu_types_pkg::elem_t         mat_wdata,
    input  logic                         start_mat_mul,
    output logic                         done_mat_mul,
    output logic                         load_wr,
    output logic [$clog2(VEC_LEN)-1:0]   load_idx,
    output tpu_types_pkg::result_t       load_data
);
    import tpu_types_pkg::*;

    localparam int IDX_W = $clog2(VEC_LEN);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(VEC_LEN - 1);

    elem_t            w_mem [VEC_LEN * VEC_LEN];
    elem_t            v_mem [VEC_LEN];
    logic             start_d, start_rise, busy, row_end;
    logic [IDX_W-1:0] row, col;
    acc_t             acc, acc_sum;
    result_t          product, acc_sat;

    always_ff @(posedge clk) begin
        if (mat_wr) begin
            if (mat_is_vector) v_mem[mat_idx[IDX_W-1:0]] <= mat_wdata;
            else               w_mem[mat_idx] <= mat_wdata;
        end
    end

    // One product per cycle, walking each row left to right
    assign product    = w_mem[{row, col}] * v_mem[col];
    assign acc_sum    = acc + product;
    assign start_rise = start_mat_mul && !start_d;
    assign row_end    = busy && (col == LAST);

    always_comb begin
        if (acc_sum > RESULT_MAX)      acc_sat = RESULT_MAX;
        else if (acc_sum < RESULT_MIN) acc_sat = RESULT_MIN;
        else                           acc_sat = acc_sum[15:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start_d      <= 1'b0;
            busy         <= 1'b0;
            done_mat_mul <= 1'b0;
            load_wr      <= 1'b0;
            row          <= '0;
            col          <= '0;
        end else begin
            start_d      <= start_mat_mul;
            done_mat_mul <= 1'b0;
            load_wr      <= row_end;
            if (start_rise) begin
                busy <= 1'b1;
                row  <= '0;
                col  <= '0;
            end else if (row_end) begin
                col <= '0;
                if (row == LAST) begin
                    busy         <= 1'b0;
                    done_mat_mul <= 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end else if (busy) begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_rise || row_end) acc <= '0;
        else if (busy)             acc <= acc_sum;
        if (row_end) begin
            load_idx  <= row;
            load_data <= acc_sat;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tpu_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_cfg_regs #(
    parameter int VEC_LEN = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           reg_wr,
    input  logic                           reg_rd,
    input  tpu_regs_pkg::reg_addr_t        reg_addr,
    input  tpu_regs_pkg::reg_data_t        reg_wdata,
    output tpu_regs_pkg::reg_data_t        reg_rdata,
    output logic                           reg_rvalid,
    input  logic                           done_tpu,
    output logic                           start_tpu,
    output logic                           enable_matmul,
    output logic                           enable_norm,
    output logic                           enable_pool,
    output logic                           enable_activation,
    output logic                           keep_raw,
    output tpu_types_pkg::result_t         mean,
    output logic [7:0]                     inv_var,
    output logic                           mat_wr,
    output logic                           mat_is_vector,
    output logic [2*$clog2(VEC_LEN)-1:0]   mat_idx,
    output tpu_types_pkg::elem_t           mat_wdata,
    output logic [$clog2(VEC_LEN)-1:0]     res_idx,
    input  tpu_types_pkg::result_t         res_data
);
    import tpu_types_pkg::*;
    import tpu_regs_pkg::*;

    localparam int IDX_W = $clog2(VEC_LEN);

    reg_addr_t vec_off, res_off, mat_off;
    logic      in_vec, in_res, in_mat;
    reg_data_t rd_mux;

    // An offset wraps high when the address lies below its window base
    assign vec_off = reg_addr - REG_VECTOR_B_BASE;
    assign res_off = reg_addr - REG_RESULT_BASE;
    assign mat_off = reg_addr - REG_MATRIX_A_BASE;
    assign in_vec  = (reg_addr >= REG_VECTOR_B_BASE) && (vec_off < reg_addr_t'(VEC_LEN));
    assign in_res  = (reg_addr >= REG_RESULT_BASE) && (res_off < reg_addr_t'(VEC_LEN));
    assign in_mat  = (reg_addr >= REG_MATRIX_A_BASE) &&
                     (mat_off < reg_addr_t'(VEC_LEN * VEC_LEN));

    // Element writes pass straight through to the multiplier stores
    assign mat_wr        = reg_wr && (in_vec || in_mat);
    assign mat_is_vector = in_vec;
    assign mat_idx       = in_vec ? {{IDX_W{1'b0}}, vec_off[IDX_W-1:0]}
                                  : mat_off[2*IDX_W-1:0];
    assign mat_wdata     = elem_t'(reg_wdata[7:0]);
    assign res_idx       = res_off[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            start_tpu         <= 1'b0;
            enable_matmul     <= 1'b0;
            enable_norm       <= 1'b0;
            enable_pool       <= 1'b0;
            enable_activation <= 1'b0;
            keep_raw          <= 1'b0;
            mean              <= '0;
            inv_var           <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_CTRL: begin
                    start_tpu         <= reg_wdata[CTRL_START];
                    enable_matmul     <= reg_wdata[CTRL_EN_MATMUL];
                    enable_norm       <= reg_wdata[CTRL_EN_NORM];
                    enable_pool       <= reg_wdata[CTRL_EN_POOL];
                    enable_activation <= reg_wdata[CTRL_EN_ACT];
                    keep_raw          <= reg_wdata[CTRL_KEEP_RAW];
                end
                REG_MEAN:    mean    <= result_t'(reg_wdata[15:0]);
                REG_INV_VAR: inv_var <= reg_wdata[7:0];
                default: ;
            endcase
        end
    end

    ////////////////////////////// Read side
    always_comb begin
        rd_mux = '0;
        if (reg_addr == REG_CTRL) begin
            rd_mux[CTRL_START]     = start_tpu;
            rd_mux[CTRL_EN_MATMUL] = enable_matmul;
            rd_mux[CTRL_EN_NORM]   = enable_norm;
            rd_mux[CTRL_EN_POOL]   = enable_pool;
            rd_mux[CTRL_EN_ACT]    = enable_activation;
            rd_mux[CTRL_KEEP_RAW]  = keep_raw;
        end else if (reg_addr == REG_STATUS) begin
            rd_mux[STATUS_DONE] = done_tpu;
        end else if (reg_addr == REG_MEAN) begin
            rd_mux = {{16{mean[15]}}, mean};
        end else if (reg_addr == REG_INV_VAR) begin
            rd_mux = {24'd0, inv_var};
        end else if (in_res) begin
            rd_mux = {{16{res_data[15]}}, res_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tpu_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_tpu,
    input  logic                    enable_matmul,
    input  logic                    enable_norm,
    input  logic                    enable_pool,
    input  logic                    enable_activation,
    input  logic                    keep_raw,
    input  logic                    done_mat_mul,
    input  logic                    post_done,
    output logic                    start_mat_mul,
    output logic                    post_start,
    output tpu_types_pkg::post_op_t post_op,
    output logic                    done_tpu
);
    import tpu_types_pkg::*;

    ctrl_state_t state, next_state;
    post_op_t    next_op;
    logic        pass_entry;

    ////////////////////////////// Sequencing
    // The multiply always runs first, then norm, pool and activation in that order
    always_comb begin
        next_state = state;
        case (state)
            ST_INIT: begin
                if (start_tpu && enable_matmul) begin
                    next_state = ST_MATMUL;
                end
            end
            ST_MATMUL: begin
                if (done_mat_mul) begin
                    if (keep_raw)               next_state = ST_DONE;
                    else if (enable_norm)       next_state = ST_NORM;
                    else if (enable_pool)       next_state = ST_POOL;
                    else if (enable_activation) next_state = ST_ACTIVATION;
                    else                        next_state = ST_DONE;
                end
            end
            ST_NORM: begin
                if (post_done) begin
                    if (enable_pool)            next_state = ST_POOL;
                    else if (enable_activation) next_state = ST_ACTIVATION;
                    else                        next_state = ST_DONE;
                end
            end
            ST_POOL: begin
                if (post_done) begin
                    next_state = enable_activation ? ST_ACTIVATION : ST_DONE;
                end
            end
            ST_ACTIVATION: begin
                if (post_done) begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE: begin
                // The host leaves this state by clearing start
                if (!start_tpu) begin
                    next_state = ST_INIT;
                end
            end
            default: next_state = ST_INIT;
        endcase
    end

    assign pass_entry = (next_state != state) &&
                        (next_state inside {ST_NORM, ST_POOL, ST_ACTIVATION});

    always_comb begin
        case (next_state)
            ST_NORM: next_op = OP_NORM;
            ST_POOL: next_op = OP_POOL;
            default: next_op = OP_RELU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_INIT;
            start_mat_mul <= 1'b0;
            post_start    <= 1'b0;
            post_op       <= OP_NORM;
            done_tpu      <= 1'b0;
        end else begin
            state <= next_state;
            // Level request to the multiplier, held until its done pulse
            start_mat_mul <= (next_state == ST_MATMUL);
            post_start    <= pass_entry;
            post_op       <= next_op;
            done_tpu      <= (state == ST_DONE) && start_tpu;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tpu_regs_pkg.sv ====
`default_nettype none

package tpu_regs_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Element windows in the register map take one address per entry
    localparam reg_addr_t REG_CTRL          = 8'h00;
    localparam reg_addr_t REG_STATUS        = 8'h04;
    localparam reg_addr_t REG_MEAN          = 8'h08;
    localparam reg_addr_t REG_INV_VAR       = 8'h0c;
    localparam reg_addr_t REG_VECTOR_B_BASE = 8'h20;
    localparam reg_addr_t REG_RESULT_BASE   = 8'h30;
    localparam reg_addr_t REG_MATRIX_A_BASE = 8'h40;

    // Bit positions in REG_CTRL and REG_STATUS
    localparam int CTRL_START     = 0;
    localparam int CTRL_EN_MATMUL = 1;
    localparam int CTRL_EN_NORM   = 2;
    localparam int CTRL_EN_POOL   = 3;
    localparam int CTRL_EN_ACT    = 4;
    localparam int CTRL_KEEP_RAW  = 5;
    localparam int STATUS_DONE    = 0;

endpackage

`default_nettype wire

// ==== logic/tpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tpu_top #(
    parameter int VEC_LEN = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  tpu_regs_pkg::reg_addr_t reg_addr,
    input  tpu_regs_pkg::reg_data_t reg_wdata,
    output tpu_regs_pkg::reg_data_t reg_rdata,
    output logic                    reg_rvalid
);
    import tpu_types_pkg::*;

    localparam int IDX_W = $clog2(VEC_LEN);

    logic             start_tpu, done_tpu, keep_raw;
    logic             enable_matmul, enable_norm, enable_pool, enable_activation;
    result_t          mean;
    logic [7:0]       inv_var;
    logic             mat_wr, mat_is_vector;
    logic [2*IDX_W-1:0] mat_idx;
    elem_t            mat_wdata;
    logic [IDX_W-1:0] res_idx, load_idx;
    result_t          res_data, load_data;
    logic             start_mat_mul, done_mat_mul, load_wr;
    logic             post_start, post_done;
    post_op_t         post_op;

    tpu_cfg_regs #(.VEC_LEN(VEC_LEN)) u_cfg_regs (
        .clk, .reset, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .done_tpu, .start_tpu, .enable_matmul, .enable_norm, .enable_pool,
        .enable_activation, .keep_raw, .mean, .inv_var,
        .mat_wr, .mat_is_vector, .mat_idx, .mat_wdata, .res_idx, .res_data
    );

    tpu_control u_control (
        .clk, .reset, .start_tpu, .enable_matmul, .enable_norm, .enable_pool,
        .enable_activation, .keep_raw, .done_mat_mul, .post_done,
        .start_mat_mul, .post_start, .post_op, .done_tpu
    );

    mat_mul_unit #(.VEC_LEN(VEC_LEN)) u_mat_mul (
        .clk, .reset, .mat_wr, .mat_is_vector, .mat_idx, .mat_wdata, .start_mat_mul,
        .done_mat_mul, .load_wr, .load_idx, .load_data
    );

    vector_post_unit #(.VEC_LEN(VEC_LEN)) u_post (
        .clk, .reset, .load_wr, .load_idx, .load_data, .post_start, .post_op,
        .mean, .inv_var, .res_idx, .post_done, .res_data
    );

endmodule

`default_nettype wire

// ==== logic/tpu_types_pkg.sv ====
`default_nettype none

package tpu_types_pkg;

    // Element and result formats of the tile datapath
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [15:0] result_t;
    typedef logic signed [19:0] acc_t;

    typedef enum logic [2:0] {
        ST_INIT, ST_MATMUL, ST_NORM, ST_POOL, ST_ACTIVATION, ST_DONE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        OP_NORM, OP_POOL, OP_RELU
    } post_op_t;

    localparam result_t RESULT_MAX = 16'sh7fff;
    localparam result_t RESULT_MIN = -16'sh8000;

endpackage

`default_nettype wire

// ==== logic/vector_post_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module vector_post_unit #(
    parameter int VEC_LEN = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_wr,
    input  logic [$clog2(VEC_LEN)-1:0]  load_idx,
    input  tpu_types_pkg::result_t      load_data,
    input  logic                        post_start,
    input  tpu_types_pkg::post_op_t     post_op,
    input  tpu_types_pkg::result_t      mean,
    input  logic [7:0]                  inv_var,
    input  logic [$clog2(VEC_LEN)-1:0]  res_idx,
    output logic                        post_done,
    output tpu_types_pkg::result_t      res_data
);
    import tpu_types_pkg::*;

    localparam int IDX_W = $clog2(VEC_LEN);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(VEC_LEN - 1);

    result_t            res_mem [VEC_LEN];
    logic               busy;
    post_op_t           op_q;
    logic [IDX_W-1:0]   idx, pool_lo, pool_hi;
    result_t            cur, pool_a, pool_b, norm_sat, pass_val;
    logic signed [16:0] norm_diff;
    logic signed [25:0] norm_prod;
    logic signed [17:0] norm_shift;

    assign res_data = res_mem[res_idx];
    assign cur      = res_mem[idx];

    ////////////////////////////// Pass datapath
    // The scale is unsigned Q0.8, so the product drops eight fraction bits
    assign norm_diff  = cur - mean;
    assign norm_prod  = norm_diff * $signed({1'b0, inv_var});
    assign norm_shift = norm_prod[25:8];

    always_comb begin
        if (norm_shift > RESULT_MAX)      norm_sat = RESULT_MAX;
        else if (norm_shift < RESULT_MIN) norm_sat = RESULT_MIN;
        else                              norm_sat = norm_shift[15:0];
    end

    // Pool reads 2i and 2i+1, which lie at or ahead of the write index
    assign pool_lo = idx << 1;
    assign pool_hi = pool_lo | IDX_W'(1);
    assign pool_a  = res_mem[pool_lo];
    assign pool_b  = res_mem[pool_hi];

    always_comb begin
        case (op_q)
            OP_NORM: pass_val = norm_sat;
            OP_POOL: begin
                // The upper half of the vector is cleared
                if (idx[IDX_W-1])         pass_val = '0;
                else if (pool_a > pool_b) pass_val = pool_a;
                else                      pass_val = pool_b;
            end
            default: pass_val = cur[15] ? '0 : cur;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_wr)   res_mem[load_idx] <= load_data;
        else if (busy) res_mem[idx] <= pass_val;
    end

    ////////////////////////////// Pass control
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            post_done <= 1'b0;
            idx       <= '0;
            op_q      <= OP_NORM;
        end else begin
            post_done <= 1'b0;
            if (post_start) begin
                busy <= 1'b1;
                idx  <= '0;
                op_q <= post_op;
            end else if (busy) begin
                if (idx == LAST) begin
                    busy      <= 1'b0;
                    post_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tile regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_tpu -f files.f -o tb_tpu_sim

# The simulation status alone is not trusted, the pass line decides
output=$(./obj_dir/tb_tpu_sim 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "Regression passed"

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 10
) (
    output logic clk
);

    // Free-running clock with a 20 ns period by default
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_tpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tpu;
    import tpu_regs_pkg::*;

    localparam int VEC_LEN        = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 200;
    localparam int NUM_CASES      = 9;
    localparam int MAT_SIZE       = VEC_LEN * VEC_LEN;
    localparam int unsigned SEED  = 32'h8f15_9205;

    // Bus writes take two cycles and reads about two, plus the multiply and three passes
    localparam int WORST_CASE_CYCLES = 2 * (MAT_SIZE + VEC_LEN + 4) + (MAT_SIZE + 1) +
                                       3 * (VEC_LEN + 1) + 3 * (VEC_LEN + 8) + 40;
    localparam int MAX_POLLS         = WORST_CASE_CYCLES;
    localparam int WATCHDOG_CYCLES   = NUM_CASES * 4 * WORST_CASE_CYCLES +
                                       4 * (RESET_CYCLES + IDLE_CYCLES);

    typedef struct packed {
        logic        en_norm;
        logic        en_pool;
        logic        en_act;
        logic        keep_raw;
        logic        edge_data;
        logic [15:0] mean;
        logic [7:0]  inv_var;
    } case_t;

    ////////////////////////////// Case table
    // Columns are norm, pool, act, keep raw, edge data, mean, scale
    localparam case_t CASES [NUM_CASES] = '{
        '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0000, 8'h00},
        '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00},
        '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0064, 8'h40},
        '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000, 8'h00},
        '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'h0000, 8'h00},
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 16'hffce, 8'hc8},
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'h1000, 8'hff},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 16'h0010, 8'h80},
        '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 16'h8000, 8'hff}
    };

    logic        clk;
    logic        reset;
    logic        reg_wr;
    logic        reg_rd;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        reg_rvalid;
    int unsigned cycle_count;

    logic signed [7:0] w_vals [MAT_SIZE];
    logic signed [7:0] v_vals [VEC_LEN];
    int                exp_res [VEC_LEN];

    tb_clock_gen u_clock_gen (.clk(clk));

    tpu_top #(.VEC_LEN(VEC_LEN)) u_dut (
        .clk, .reset, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////// Reporting
    task automatic end_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input reg_data_t got, input reg_data_t expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
            end_with_failure();
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        end_with_failure();
    end

    ////////////////////////////// Bus access
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // The response is sampled on the falling edge, where it is stable
    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(negedge clk);
        check_value("reg_rvalid", reg_data_t'(reg_rvalid), 32'd0);
        @(posedge clk);
        reg_rd <= 1'b0;
        // The response is valid exactly one cycle after the strobe
        @(negedge clk);
        check_value("reg_rvalid", reg_data_t'(reg_rvalid), 32'd1);
        data = reg_rdata;
    endtask

    function automatic reg_data_t ctrl_word(input logic start, input logic en_mm, input case_t c);
        reg_data_t w;
        w = '0;
        w[CTRL_START]     = start;
        w[CTRL_EN_MATMUL] = en_mm;
        w[CTRL_EN_NORM]   = c.en_norm;
        w[CTRL_EN_POOL]   = c.en_pool;
        w[CTRL_EN_ACT]    = c.en_act;
        w[CTRL_KEEP_RAW]  = c.keep_raw;
        return w;
    endfunction

    ////////////////////////////// Stimulus and model
    // Edge rows drive the dot products into both saturation limits
    function automatic logic signed [7:0] edge_weight(input int r, input int c);
        case (r % 4)
            0:       return 8'h80;
            1:       return 8'h7f;
            2:       return (c % 2 == 0) ? 8'h80 : 8'h7f;
            default: return (c == r % VEC_LEN) ? 8'h7f : 8'h00;
        endcase
    endfunction

    task automatic fill_operands(input case_t c);
        for (int k = 0; k < MAT_SIZE; k++) begin
            w_vals[k] = c.edge_data ? edge_weight(k / VEC_LEN, k % VEC_LEN) : 8'($urandom());
        end
        for (int k = 0; k < VEC_LEN; k++) begin
            v_vals[k] = c.edge_data ? 8'h80 : 8'($urandom());
        end
    endtask

    function automatic int saturate_result(input int x);
        if (x > 32767) return 32767;
        if (x < -32768) return -32768;
        return x;
    endfunction

    task automatic compute_expected(input case_t c);
        int acc;
        int tmp [VEC_LEN];
        for (int r = 0; r < VEC_LEN; r++) begin
            acc = 0;
            for (int col = 0; col < VEC_LEN; col++) begin
                acc += int'(w_vals[r * VEC_LEN + col]) * int'(v_vals[col]);
            end
            exp_res[r] = saturate_result(acc);
        end
        if (!c.keep_raw) begin
            // Passes run as norm, then pool, then relu
            if (c.en_norm) begin
                for (int i = 0; i < VEC_LEN; i++) begin
                    acc = (exp_res[i] - int'($signed(c.mean))) * int'(c.inv_var);
                    exp_res[i] = saturate_result(acc >>> 8);
                end
            end
            if (c.en_pool) begin
                tmp = exp_res;
                for (int i = 0; i < VEC_LEN; i++) begin
                    if (i < VEC_LEN / 2) begin
                        exp_res[i] = (tmp[2*i] > tmp[2*i+1]) ? tmp[2*i] : tmp[2*i+1];
                    end else begin
                        exp_res[i] = 0;
                    end
                end
            end
            if (c.en_act) begin
                for (int i = 0; i < VEC_LEN; i++) begin
                    if (exp_res[i] < 0) exp_res[i] = 0;
                end
            end
        end
    endtask

    task automatic run_case(input int n, input case_t c);
        reg_data_t data;
        int        polls;
        fill_operands(c);
        compute_expected(c);
        for (int k = 0; k < MAT_SIZE; k++) begin
            bus_write(reg_addr_t'(REG_MATRIX_A_BASE + k), {24'd0, w_vals[k]});
        end
        for (int k = 0; k < VEC_LEN; k++) begin
            bus_write(reg_addr_t'(REG_VECTOR_B_BASE + k), {24'd0, v_vals[k]});
        end
        bus_write(REG_MEAN, {16'd0, c.mean});
        bus_write(REG_INV_VAR, {24'd0, c.inv_var});
        bus_write(REG_CTRL, ctrl_word(1'b1, 1'b1, c));
        polls = 0;
        bus_read(REG_STATUS, data);
        while (!data[STATUS_DONE]) begin
            polls++;
            if (polls > MAX_POLLS) begin
                $display("Case %0d: done was never set", n);
                end_with_failure();
            end
            bus_read(REG_STATUS, data);
        end
        // Done has to hold for as long as start stays set
        repeat (3) begin
            bus_read(REG_STATUS, data);
            check_value("status", data, 32'd1);
        end
        for (int i = 0; i < VEC_LEN; i++) begin
            bus_read(reg_addr_t'(REG_RESULT_BASE + i), data);
            check_value($sformatf("result[%0d]", i), data, reg_data_t'(exp_res[i]));
        end
        bus_write(REG_CTRL, ctrl_word(1'b0, 1'b1, c));
        bus_read(REG_STATUS, data);
        check_value("status", data, 32'd0);
    endtask

    ////////////////////////////// Main sequence
    initial begin
        reg_data_t   data;
        int unsigned idle_start;
        reg_addr_t   unmapped [4];
        reset       <= 1'b1;
        reg_wr      <= 1'b0;
        reg_rd      <= 1'b0;
        reg_addr    <= '0;
        reg_wdata   <= '0;
        cycle_count <= 0;
        void'($urandom(SEED));
        unmapped[0] = 8'h14;
        unmapped[1] = reg_addr_t'(REG_VECTOR_B_BASE + VEC_LEN);
        unmapped[2] = reg_addr_t'(REG_RESULT_BASE + VEC_LEN);
        unmapped[3] = reg_addr_t'(REG_MATRIX_A_BASE + MAT_SIZE);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 4; i++) begin
            bus_read(unmapped[i], data);
            check_value($sformatf("unmapped 0x%02h", unmapped[i]), data, 32'd0);
        end

        // A start without the matmul enable must leave the tile idle
        bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, CASES[5]));
        idle_start = cycle_count;
        while (cycle_count - idle_start < IDLE_CYCLES) begin
            bus_read(REG_STATUS, data);
            check_value("status", data, 32'd0);
        end
        bus_write(REG_CTRL, 32'd0);

        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(n, CASES[n]);
            $display("Case %0d checked", n);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
